/* verilog/bk_pkg.sv */
package bk_pkg;

	// ------------------------------------------------------------------
	// bus bundles
	// ------------------------------------------------------------------
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        sync;
		logic        din;
		logic        dout;
		logic        wtbt;   // byte operation
		logic        iako;   // interrupt acknowledge
		logic        ifetch;
		logic [2:0]  pri;    // psw priority
	} cpu_req_t;

	typedef struct packed {
		logic [15:0] rdata;
		logic        rply;
		logic        virq;
		logic        error;
	} cpu_resp_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic        wt;
		logic        rd;
		logic        byte_op;
	} mem_req_t;

	typedef enum logic [1:0] {
		SPACE_RAM,
		SPACE_ROM,
		SPACE_REG
	} space_t;

	typedef enum logic [2:0] {
		SEL_NONE,
		SEL_KBD_STATE,
		SEL_KBD_DATA,
		SEL_ROLL,
		SEL_USR,
		SEL_INIT
	} reg_sel_t;

	// ------------------------------------------------------------------
	// address map and register constants
	// ------------------------------------------------------------------
	localparam logic [8:0]  REG_PAGE_TAG  = 9'b111111111; // 177600 and up
	localparam logic [6:0]  REG_KBD_STATE = 7'o060;
	localparam logic [6:0]  REG_KBD_DATA  = 7'o062;
	localparam logic [6:0]  REG_ROLL      = 7'o064;
	localparam logic [6:0]  REG_USR       = 7'o114;
	localparam logic [6:0]  REG_INIT      = 7'o116;

	localparam logic [15:0] ROLL_RESET    = 16'o001330;
	localparam logic [7:0]  INIT_HI       = 8'o200;     // start address high byte
	localparam logic [15:0] VEC_KBD       = 16'o000060;
	localparam logic [15:0] VEC_KBD_AR2   = 16'o000274;

endpackage

/* verilog/bk_addr_decoder.sv */
module bk_addr_decoder (
	input  logic [15:0]      addr,
	output bk_pkg::space_t   space,
	output bk_pkg::reg_sel_t sel
);
	import bk_pkg::*;

	logic reg_page;

	assign reg_page = (addr[15:7] == REG_PAGE_TAG);

	// ------------------------------------------------------------------
	// address space
	// ------------------------------------------------------------------
	always_comb begin
		if (!addr[15])
			space = SPACE_RAM;    // lower 32K
		else if (reg_page)
			space = SPACE_REG;
		else
			space = SPACE_ROM;
	end

	// register select within the system page
	always_comb begin
		sel = SEL_NONE;
		if (reg_page) begin
			case (addr[6:0])
				REG_KBD_STATE: sel = SEL_KBD_STATE;
				REG_KBD_DATA:  sel = SEL_KBD_DATA;
				REG_ROLL:      sel = SEL_ROLL;
				REG_USR:       sel = SEL_USR;
				REG_INIT:      sel = SEL_INIT;
				default:       sel = SEL_NONE;    // unimplemented register
			endcase
		end
	end

endmodule

/* verilog/bk_bus_sequencer.sv */
module bk_bus_sequencer (
	input  logic             m_clock,
	input  logic             p_reset,
	input  logic             ce,
	input  logic             sync,
	input  logic             din,
	input  logic             dout,
	input  bk_pkg::space_t   space,
	input  bk_pkg::reg_sel_t sel,
	input  logic             mem_rdy,
	input  logic             ifetch,
	input  logic             stopkey,
	output logic             sync_edge,
	output logic             wr_stb,
	output logic             rply,
	output logic             error
);
	import bk_pkg::*;

	logic sync_q;
	logic rply_latch;   // cycle started, reply pending
	logic fault;
	logic bad_reg;
	logic rom_write;
	logic fault_cond;
	logic active;

	assign sync_edge = sync & ~sync_q;

	// ------------------------------------------------------------------
	// fault detection
	// ------------------------------------------------------------------
	assign bad_reg    = (space == SPACE_REG) && (sel == SEL_NONE);
	assign rom_write  = (space == SPACE_ROM) && dout;
	assign fault_cond = bad_reg | rom_write;

	// any strobe counts as bus activity for the fault register
	assign active = sync | din | dout;

	always_ff @(posedge m_clock) begin
		if (p_reset) begin
			fault <= 1'b0;
		end else if (ce) begin
			if (active)
				fault <= fault_cond;    // held between cycles
		end
	end

	// ------------------------------------------------------------------
	// reply and write strobe
	// ------------------------------------------------------------------
	always_ff @(posedge m_clock) begin
		if (p_reset) begin
			sync_q     <= 1'b0;
			rply_latch <= 1'b0;
			wr_stb     <= 1'b0;
			rply       <= 1'b0;
		end else if (ce) begin
			sync_q <= sync;

			if (sync_edge) begin
				rply_latch <= 1'b1;
				wr_stb     <= dout;    // level strobe for the whole cycle
			end

			if (rply_latch && mem_rdy && !fault)
				rply <= 1'b1;    // sticky until sync drops

			// end of cycle
			if (!sync) begin
				rply_latch <= 1'b0;
				wr_stb     <= 1'b0;
				rply       <= 1'b0;
			end
		end
	end

	// stop key traps on the next instruction fetch
	assign error = fault | (ifetch & stopkey);

endmodule

/* verilog/bk_sys_regs.sv */
module bk_sys_regs (
	input  logic             m_clock,
	input  logic             p_reset,
	input  logic             ce,
	input  bk_pkg::reg_sel_t sel,
	input  logic             wr_stb,
	input  logic             din,
	input  logic             iako,
	input  logic [15:0]      wdata,
	input  logic [2:0]       pri,
	input  logic [7:0]       kbd_data,
	input  logic             kbd_available,
	input  logic             kbd_ar2,
	input  logic             stopkey,
	input  logic             keydown,
	input  logic             tape_in,
	output logic [15:0]      reg_rdata,
	output logic             virq,
	output logic             read_kbd,
	output logic             tape_out,
	output logic [7:0]       roll_out,
	output logic [15:0]      vector
);
	import bk_pkg::*;

	logic        kbd_int_mask;   // bit 6 of kbd state, 1 blocks irq
	logic [15:0] roll;
	logic        stopkey_latch;
	logic        init_latch;     // init register written since last read
	logic        init_rd_q;
	logic        rd_en;
	logic        init_rd;
	logic        wr_en;

	// a vector fetch is not a register read
	assign rd_en   = din & ~iako;
	assign init_rd = rd_en & (sel == SEL_INIT);
	assign wr_en   = wr_stb & ~iako;

	// ------------------------------------------------------------------
	// register writes and status latches
	// ------------------------------------------------------------------
	always_ff @(posedge m_clock) begin
		if (p_reset) begin
			kbd_int_mask  <= 1'b0;
			roll          <= ROLL_RESET;
			tape_out      <= 1'b0;
			stopkey_latch <= 1'b0;
			init_latch    <= 1'b0;
			init_rd_q     <= 1'b0;
		end else if (ce) begin
			init_rd_q <= init_rd;

			if (stopkey)
				stopkey_latch <= 1'b1;

			if (wr_en) begin
				case (sel)
					SEL_KBD_STATE: kbd_int_mask <= wdata[6];
					SEL_ROLL:      roll <= wdata;
					SEL_INIT: begin
						tape_out   <= wdata[6];
						init_latch <= 1'b1;
					end
					default: ;    // usr port ignores writes
				endcase
			end

			// latches clear once the init read has finished,
			// so the cycle itself still returns them
			if (init_rd_q && !init_rd) begin
				stopkey_latch <= 1'b0;
				init_latch    <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------------
	always_comb begin
		case (sel)
			SEL_KBD_STATE: reg_rdata = {8'h00, kbd_available, kbd_int_mask, 6'b000000};
			SEL_KBD_DATA:  reg_rdata = {8'h00, kbd_data};
			SEL_ROLL:      reg_rdata = roll;
			SEL_INIT: begin
				reg_rdata = {INIT_HI, 1'b1, ~keydown, tape_in, 2'b00,
					stopkey_latch | init_latch, 2'b00};
			end
			default:       reg_rdata = 16'h0000;    // usr port reads zero
		endcase
	end

	assign read_kbd = rd_en & (sel == SEL_KBD_DATA);    // acknowledge to scanner
	assign roll_out = roll[7:0];

	// ------------------------------------------------------------------
	// keyboard interrupt
	// ------------------------------------------------------------------
	assign virq   = kbd_available & ~kbd_int_mask & (pri == 3'd0);
	assign vector = kbd_ar2 ? VEC_KBD_AR2 : VEC_KBD;

endmodule

/* verilog/bk_mem_port.sv */
module bk_mem_port (
	input  logic            m_clock,
	input  logic            p_reset,
	input  logic            ce,
	input  logic            sync_edge,
	input  logic            wr_stb,
	input  logic            din,
	input  logic            iako,
	input  logic [15:0]     addr,
	input  logic [15:0]     wdata,
	input  logic            wtbt,
	input  bk_pkg::space_t  space,
	input  logic [15:0]     mem_rdata,
	input  logic [15:0]     reg_rdata,
	input  logic [15:0]     vector,
	output bk_pkg::mem_req_t mem_req,
	output logic [15:0]     rdata
);
	import bk_pkg::*;

	logic [15:0] wdata_q;
	logic [15:0] rd_q;
	logic [15:0] mem_rd_word;
	logic        odd_byte;
	logic        in_ram;
	logic        in_mem;

	assign odd_byte = wtbt & addr[0];
	assign in_ram   = (space == SPACE_RAM);
	assign in_mem   = (space == SPACE_RAM) || (space == SPACE_ROM);

	// ------------------------------------------------------------------
	// write path
	// ------------------------------------------------------------------
	always_ff @(posedge m_clock) begin
		if (ce && sync_edge)
			wdata_q <= odd_byte ? {wdata[7:0], wdata[7:0]} : wdata;    // high lane copy
	end

	assign mem_req.addr    = addr;
	assign mem_req.wdata   = wdata_q;
	assign mem_req.wt      = wr_stb & in_ram;
	assign mem_req.rd      = din & in_mem;
	assign mem_req.byte_op = wtbt;

	// ------------------------------------------------------------------
	// read path
	// ------------------------------------------------------------------
	always_comb begin
		if (!wtbt)
			mem_rd_word = mem_rdata;
		else if (addr[0])
			mem_rd_word = {8'h00, mem_rdata[15:8]};    // odd byte
		else
			mem_rd_word = {8'h00, mem_rdata[7:0]};
	end

	always_ff @(posedge m_clock) begin
		if (p_reset) begin
			rd_q <= 16'h0000;
		end else if (ce && din) begin
			rd_q <= (space == SPACE_REG) ? reg_rdata : mem_rd_word;
		end
	end

	// vector goes straight out during acknowledge
	assign rdata = iako ? vector : rd_q;

endmodule

/* verilog/bk_bus_core.sv */
module bk_bus_core (
	input  logic              m_clock,
	input  logic              p_reset,
	input  logic              ce,
	input  bk_pkg::cpu_req_t  cpu_req,
	output bk_pkg::cpu_resp_t cpu_resp,
	output bk_pkg::mem_req_t  mem_req,
	input  logic [15:0]       mem_rdata,
	input  logic              mem_rdy,
	input  logic [7:0]        kbd_data,
	input  logic              kbd_available,
	input  logic              kbd_ar2,
	input  logic              stopkey,
	input  logic              keydown,
	output logic              read_kbd,
	input  logic              tape_in,
	output logic              tape_out,
	output logic [7:0]        roll_out
);
	import bk_pkg::*;

	space_t      space;
	reg_sel_t    sel;
	logic        sync_edge;
	logic        wr_stb;
	logic [15:0] reg_rdata;
	logic [15:0] vector;

	// ------------------------------------------------------------------
	// bus control
	// ------------------------------------------------------------------
	bk_bus_sequencer u_bk_bus_sequencer (
		.m_clock   (m_clock),
		.p_reset   (p_reset),
		.ce        (ce),
		.sync      (cpu_req.sync),
		.din       (cpu_req.din),
		.dout      (cpu_req.dout),
		.space     (space),
		.sel       (sel),
		.mem_rdy   (mem_rdy),
		.ifetch    (cpu_req.ifetch),
		.stopkey   (stopkey),
		.sync_edge (sync_edge),
		.wr_stb    (wr_stb),
		.rply      (cpu_resp.rply),
		.error     (cpu_resp.error)
	);

	bk_addr_decoder u_bk_addr_decoder (
		.addr  (cpu_req.addr),
		.space (space),
		.sel   (sel)
	);

	// ------------------------------------------------------------------
	// system registers and memory
	// ------------------------------------------------------------------
	bk_sys_regs u_bk_sys_regs (
		.m_clock       (m_clock),
		.p_reset       (p_reset),
		.ce            (ce),
		.sel           (sel),
		.wr_stb        (wr_stb),
		.din           (cpu_req.din),
		.iako          (cpu_req.iako),
		.wdata         (cpu_req.wdata),
		.pri           (cpu_req.pri),
		.kbd_data      (kbd_data),
		.kbd_available (kbd_available),
		.kbd_ar2       (kbd_ar2),
		.stopkey       (stopkey),
		.keydown       (keydown),
		.tape_in       (tape_in),
		.reg_rdata     (reg_rdata),
		.virq          (cpu_resp.virq),
		.read_kbd      (read_kbd),
		.tape_out      (tape_out),
		.roll_out      (roll_out),
		.vector        (vector)
	);

	bk_mem_port u_bk_mem_port (
		.m_clock   (m_clock),
		.p_reset   (p_reset),
		.ce        (ce),
		.sync_edge (sync_edge),
		.wr_stb    (wr_stb),
		.din       (cpu_req.din),
		.iako      (cpu_req.iako),
		.addr      (cpu_req.addr),
		.wdata     (cpu_req.wdata),
		.wtbt      (cpu_req.wtbt),
		.space     (space),
		.mem_rdata (mem_rdata),
		.reg_rdata (reg_rdata),
		.vector    (vector),
		.mem_req   (mem_req),
		.rdata     (cpu_resp.rdata)
	);

endmodule

/* tb/tb_bk_bus_core.sv */
module tb_bk_bus_core;
	import bk_pkg::*;

	localparam int          CYCLE_LIMIT = 4000;    // ~60 bus cycles, 40 edges worst case, plus reset
	localparam int          REPLY_LIMIT = 40;
	localparam logic [31:0] RAND_SEED   = 32'h2d66e140;
	localparam logic [15:0] ROM_XOR     = 16'o125252;
	localparam logic [15:0] A_KBD_STATE = 16'o177660;
	localparam logic [15:0] A_KBD_DATA  = 16'o177662;
	localparam logic [15:0] A_ROLL      = 16'o177664;
	localparam logic [15:0] A_USR       = 16'o177714;
	localparam logic [15:0] A_INIT      = 16'o177716;
	localparam logic [15:0] A_BAD       = 16'o177700;    // unimplemented register

	logic        m_clock;
	logic        p_reset;
	logic        ce = 1'b1;
	cpu_req_t    cpu_req;
	cpu_resp_t   cpu_resp;
	mem_req_t    mem_req;
	logic [15:0] mem_rdata;
	logic        mem_rdy;
	logic [7:0]  kbd_data;
	logic        kbd_available;
	logic        kbd_ar2;
	logic        stopkey;
	logic        keydown;
	logic        read_kbd;
	logic        tape_in;
	logic        tape_out;
	logic [7:0]  roll_out;

	logic [15:0] ram [0:16383];    // 32K bytes of RAM as words
	int          cycles = 0;
	int          kbd_reads = 0;
	int          last_wait;        // edges from sync drive to reply
	logic        ce_random = 1'b0;

	bk_bus_core u_bk_bus_core (
		.m_clock       (m_clock),
		.p_reset       (p_reset),
		.ce            (ce),
		.cpu_req       (cpu_req),
		.cpu_resp      (cpu_resp),
		.mem_req       (mem_req),
		.mem_rdata     (mem_rdata),
		.mem_rdy       (mem_rdy),
		.kbd_data      (kbd_data),
		.kbd_available (kbd_available),
		.kbd_ar2       (kbd_ar2),
		.stopkey       (stopkey),
		.keydown       (keydown),
		.read_kbd      (read_kbd),
		.tape_in       (tape_in),
		.tape_out      (tape_out),
		.roll_out      (roll_out)
	);

	initial m_clock = 1'b0;
	always #10 m_clock = ~m_clock;

	// ------------------------------------------------------------------
	// external memory, run limit and clock enable
	// ------------------------------------------------------------------
	always @(posedge m_clock) begin
		if (mem_req.wt) begin
			if (!mem_req.byte_op)
				ram[mem_req.addr[14:1]] <= mem_req.wdata;
			else if (mem_req.addr[0])
				ram[mem_req.addr[14:1]][15:8] <= mem_req.wdata[15:8];    // high lane
			else
				ram[mem_req.addr[14:1]][7:0] <= mem_req.wdata[7:0];
		end
	end

	always_comb begin
		if (mem_req.addr[15])
			mem_rdata = mem_req.addr ^ ROM_XOR;    // rom contents
		else
			mem_rdata = ram[mem_req.addr[14:1]];
	end

	always @(posedge m_clock) begin
		cycles <= cycles + 1;
		if (read_kbd)
			kbd_reads <= kbd_reads + 1;
		if (cycles >= CYCLE_LIMIT)
			abort_run("timeout: the run went past its cycle limit");
	end

	always @(posedge m_clock) begin
		if (ce_random)
			ce <= 1'($urandom_range(0, 1));
		else
			ce <= 1'b1;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what);
		abort_run($sformatf("FAILED at time %0t: %s", $time, what));
	endtask

	task automatic check_value(input string what, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
			else report_mismatch($sformatf("%s: got %o, expected %o", what, got, exp));
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		assert (got === exp)
			else report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
	endtask

	wt_in_ram: assert property (@(posedge m_clock) disable iff (p_reset)
		mem_req.wt |-> !mem_req.addr[15])
		else report_mismatch("memory write strobe outside RAM");
	rd_outside_regs: assert property (@(posedge m_clock) disable iff (p_reset)
		mem_req.rd == (cpu_req.din && cpu_req.addr[15:7] != 9'o777))
		else report_mismatch("memory read strobe does not follow din outside the register page");
	rply_in_cycle: assert property (@(posedge m_clock) disable iff (p_reset)
		$rose(cpu_resp.rply) |-> cpu_req.sync)
		else report_mismatch("reply outside a bus cycle");
	rply_after_rdy: assert property (@(posedge m_clock) disable iff (p_reset)
		$rose(cpu_resp.rply) |-> $past(mem_rdy))
		else report_mismatch("reply while memory not ready");
	kbd_ack_on_read: assert property (@(posedge m_clock) disable iff (p_reset)
		read_kbd |-> (cpu_req.din && cpu_req.addr == A_KBD_DATA))
		else report_mismatch("read_kbd without a keyboard data read");

	// high byte is the start address, low byte status
	function automatic logic [15:0] init_word(input logic access, input logic down, input logic tape);
		return {8'o200, 1'b1, ~down, tape, 2'b00, access, 2'b00};
	endfunction

	// ------------------------------------------------------------------
	// CPU bus cycles
	// ------------------------------------------------------------------
	task automatic start_cycle(input logic [15:0] addr, input logic [15:0] wdata,
			input logic write, input logic byte_op, input logic ack);
		@(posedge m_clock);
		cpu_req.addr  <= addr;
		cpu_req.wdata <= wdata;
		cpu_req.wtbt  <= byte_op;
		cpu_req.iako  <= ack;
		cpu_req.sync  <= 1'b1;
		cpu_req.din   <= ~write;
		cpu_req.dout  <= write;
	endtask

	task automatic wait_reply(output logic [15:0] rdata);
		int edges;
		edges = 0;
		@(negedge m_clock);
		while (!cpu_resp.rply) begin
			@(negedge m_clock);
			edges++;
			if (edges > REPLY_LIMIT)
				abort_run($sformatf("no reply from address %o", cpu_req.addr));
		end
		last_wait = edges;
		rdata = cpu_resp.rdata;
	endtask

	task automatic end_cycle;
		int edges;
		edges = 0;
		@(posedge m_clock);
		cpu_req.sync <= 1'b0;
		cpu_req.din  <= 1'b0;
		cpu_req.dout <= 1'b0;
		cpu_req.iako <= 1'b0;
		@(negedge m_clock);
		while (cpu_resp.rply) begin
			@(negedge m_clock);
			edges++;
			if (edges > REPLY_LIMIT)
				abort_run("reply stayed high after sync was released");
		end
	endtask

	task automatic bus_cycle(input logic [15:0] addr, input logic [15:0] wdata, input logic write,
			input logic byte_op, input logic ack, output logic [15:0] rdata);
		start_cycle(addr, wdata, write, byte_op, ack);
		wait_reply(rdata);
		end_cycle();
	endtask

	task automatic write_bus(input logic [15:0] addr, input logic [15:0] data, input logic byte_op);
		logic [15:0] ignored;
		bus_cycle(addr, data, 1'b1, byte_op, 1'b0, ignored);
	endtask

	task automatic read_check(input string what, input logic [15:0] addr, input logic byte_op,
			input logic [15:0] exp);
		logic [15:0] got;
		bus_cycle(addr, 16'h0000, 1'b0, byte_op, 1'b0, got);
		check_value(what, got, exp);
	endtask

	// cycle that must fault, aborted by the CPU after 10 cycles
	task automatic fault_cycle(input string what, input logic [15:0] addr, input logic write);
		start_cycle(addr, 16'o177777, write, 1'b0, 1'b0);
		repeat (10) begin
			@(negedge m_clock);
			check_flag({what, " reply"}, cpu_resp.rply, 1'b0);
		end
		check_flag({what, " error"}, cpu_resp.error, 1'b1);
		end_cycle();
		check_flag({what, " error held"}, cpu_resp.error, 1'b1);
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		logic [15:0] addr_q [8];
		logic [15:0] data_q [8];
		logic [15:0] got;
		logic [15:0] a;
		logic [15:0] d;
		logic [7:0]  key;
		int          k;

		void'($urandom(RAND_SEED));
		p_reset       <= 1'b1;
		cpu_req       <= '0;
		mem_rdy       <= 1'b1;
		kbd_data      <= 8'h00;
		kbd_available <= 1'b0;
		kbd_ar2       <= 1'b0;
		stopkey       <= 1'b0;
		keydown       <= 1'b0;
		tape_in       <= 1'b0;
		repeat (16) @(posedge m_clock);
		p_reset <= 1'b0;

		for (int i = 0; i < 8; i++) begin
			addr_q[i] = {1'b0, 3'(i), 11'($urandom_range(0, 2047)), 1'b0};    // distinct words
			data_q[i] = 16'($urandom);
			write_bus(addr_q[i], data_q[i], 1'b0);
		end
		for (int i = 0; i < 8; i++)
			read_check("ram word", addr_q[i], 1'b0, data_q[i]);
		write_bus(16'o001000, 16'h1234, 1'b0);
		write_bus(16'o001001, 16'h00ab, 1'b1);
		read_check("odd byte write", 16'o001000, 1'b0, 16'hab34);
		write_bus(16'o001000, 16'h005c, 1'b1);
		read_check("even byte write", 16'o001000, 1'b0, 16'hab5c);
		read_check("even byte read", 16'o001000, 1'b1, 16'h005c);
		read_check("odd byte read", 16'o001001, 1'b1, 16'h00ab);

		for (int i = 0; i < 4; i++) begin
			a = {1'b1, 15'($urandom_range(0, 32'o077577))} & 16'hfffe;    // below register page
			read_check("rom read", a, 1'b0, a ^ 16'o125252);
		end
		fault_cycle("rom write", 16'o120000, 1'b1);
		read_check("read after rom fault", 16'o001000, 1'b0, 16'hab5c);
		check_flag("error after clean cycle", cpu_resp.error, 1'b0);

		read_check("roll after reset", A_ROLL, 1'b0, 16'o001330);
		check_value("roll_out after reset", {8'h00, roll_out}, 16'o000330);
		d = 16'($urandom);
		write_bus(A_ROLL, d, 1'b0);
		read_check("roll", A_ROLL, 1'b0, d);
		check_value("roll_out", {8'h00, roll_out}, {8'h00, d[7:0]});
		read_check("usr", A_USR, 1'b0, 16'h0000);
		fault_cycle("bad register", A_BAD, 1'b0);
		read_check("usr after fault", A_USR, 1'b0, 16'h0000);
		check_flag("error after clean cycle", cpu_resp.error, 1'b0);

		key = 8'($urandom);
		@(posedge m_clock);
		kbd_data      <= key;
		kbd_available <= 1'b1;
		@(negedge m_clock);
		check_flag("virq", cpu_resp.virq, 1'b1);
		@(posedge m_clock);
		cpu_req.pri <= 3'd4;
		@(negedge m_clock);
		check_flag("virq at nonzero priority", cpu_resp.virq, 1'b0);
		@(posedge m_clock);
		cpu_req.pri <= 3'd0;
		write_bus(A_KBD_STATE, 16'o000100, 1'b0);    // set interrupt mask
		check_flag("virq masked", cpu_resp.virq, 1'b0);
		read_check("kbd state masked", A_KBD_STATE, 1'b0, 16'o000300);
		write_bus(A_KBD_STATE, 16'o000000, 1'b0);
		read_check("kbd state", A_KBD_STATE, 1'b0, 16'o000200);
		check_flag("virq unmasked", cpu_resp.virq, 1'b1);
		bus_cycle(16'o000000, 16'h0000, 1'b0, 1'b0, 1'b1, got);
		check_value("vector", got, 16'o000060);
		@(posedge m_clock);
		kbd_ar2 <= 1'b1;
		bus_cycle(16'o000000, 16'h0000, 1'b0, 1'b0, 1'b1, got);
		check_value("vector with ar2", got, 16'o000274);
		k = kbd_reads;
		read_check("kbd data", A_KBD_DATA, 1'b0, {8'h00, key});
		check_flag("read_kbd pulsed", kbd_reads > k, 1'b1);
		check_flag("read_kbd released", read_kbd, 1'b0);

		check_flag("tape_out after reset", tape_out, 1'b0);
		@(posedge m_clock);
		keydown <= 1'b1;
		tape_in <= 1'b1;
		write_bus(A_INIT, 16'o000100, 1'b0);
		check_flag("tape_out", tape_out, 1'b1);
		read_check("init after write", A_INIT, 1'b0, init_word(1'b1, 1'b1, 1'b1));
		@(posedge m_clock);
		keydown <= 1'b0;
		tape_in <= 1'b0;
		read_check("init second read", A_INIT, 1'b0, init_word(1'b0, 1'b0, 1'b0));
		@(posedge m_clock);
		cpu_req.ifetch <= 1'b1;
		stopkey        <= 1'b1;
		@(negedge m_clock);
		check_flag("stop key trap", cpu_resp.error, 1'b1);
		@(posedge m_clock);
		cpu_req.ifetch <= 1'b0;
		stopkey        <= 1'b0;
		@(negedge m_clock);
		check_flag("stop key released", cpu_resp.error, 1'b0);

		read_check("timed read", 16'o001000, 1'b0, 16'hab5c);
		check_value("reply latency", 16'(last_wait), 16'd2);
		for (int i = 0; i < 3; i++) begin
			k = $urandom_range(1, 8);
			@(posedge m_clock);
			mem_rdy <= 1'b0;
			start_cycle(16'o001000, 16'h0000, 1'b0, 1'b0, 1'b0);
			repeat (k) begin
				@(negedge m_clock);
				check_flag("reply while not ready", cpu_resp.rply, 1'b0);
			end
			@(posedge m_clock);
			mem_rdy <= 1'b1;
			@(negedge m_clock);
			check_flag("reply before ready seen", cpu_resp.rply, 1'b0);
			@(negedge m_clock);
			check_flag("reply one edge after ready", cpu_resp.rply, 1'b1);
			wait_reply(got);
			check_value("read under back-pressure", got, 16'hab5c);
			end_cycle();
		end
		ce_random = 1'b1;
		for (int i = 0; i < 4; i++) begin
			a = {1'b0, 3'(i), 11'($urandom_range(0, 2047)), 1'b0};
			d = 16'($urandom);
			write_bus(a, d, 1'b0);
			read_check("read with ce toggling", a, 1'b0, d);
		end
		ce_random = 1'b0;
		repeat (2) @(posedge m_clock);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* files.f */
verilog/bk_pkg.sv
verilog/bk_addr_decoder.sv
verilog/bk_bus_sequencer.sv
verilog/bk_sys_regs.sv
verilog/bk_mem_port.sv
verilog/bk_bus_core.sv
tb/tb_bk_bus_core.sv

/* Makefile */
VERILATOR  := verilator
TOP        := tb_bk_bus_core
RTL_TOP    := bk_bus_core
FILELIST   := files.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
